//--- common/axi_bus_pkg.sv
// Widths, ID types and packed AXI channel structs of both ports, shared by RTL and testbench
package axi_bus_pkg;

  // Upstream IDs are wide, downstream IDs are compact
  localparam int unsigned SlvIdWidth = 6;
  localparam int unsigned MstIdWidth = 3;
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned LenWidth   = 8;
  localparam int unsigned RespWidth  = 2;

  typedef logic [SlvIdWidth-1:0]  slv_id_t;
  typedef logic [MstIdWidth-1:0]  mst_id_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [DataWidth/8-1:0] strb_t;
  typedef logic [LenWidth-1:0]    len_t;
  typedef logic [RespWidth-1:0]   resp_t;

  // AW and AR share one layout per port
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_ax_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_ax_t;

  // W carries no ID, so both ports use the same struct
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    slv_id_t id;
    resp_t   resp;
  } slv_b_t;

  typedef struct packed {
    mst_id_t id;
    resp_t   resp;
  } mst_b_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } slv_r_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } mst_r_t;

endpackage

//--- common/remap_pkg.sv
// Remap table entry, counter and index types plus the issue FSM states, used by the remap block
package remap_pkg;

  // One table entry per possible output ID at most
  localparam int unsigned MaxTableSize = 2 ** axi_bus_pkg::MstIdWidth;

  // Counter must hold the value MaxTableSize itself
  localparam int unsigned CntWidth = $clog2(MaxTableSize + 1);

  typedef logic [axi_bus_pkg::MstIdWidth-1:0] idx_t;
  typedef logic [CntWidth-1:0]                cnt_t;

  typedef struct packed {
    axi_bus_pkg::slv_id_t inp_id;
    // Bursts in flight on this output ID
    cnt_t                 cnt;
  } entry_t;

  // Hold keeps a stalled address request on the bus with a frozen ID
  typedef enum logic {
    Idle,
    Hold
  } issue_state_e;

endpackage

//--- remap/remap_table.sv
// Per-direction table of output IDs, tracking the input ID and in-flight count of each entry
module remap_table #(
  parameter int unsigned TableSize = remap_pkg::MaxTableSize
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  axi_bus_pkg::slv_id_t lookup_id_i,
  output logic                 exists_o,
  output logic                 exists_full_o,
  output remap_pkg::idx_t      exists_idx_o,
  output remap_pkg::idx_t      free_idx_o,
  output logic                 full_o,
  input  logic                 push_i,
  input  remap_pkg::idx_t      push_idx_i,
  input  axi_bus_pkg::slv_id_t push_id_i,
  input  logic                 pop_i,
  input  remap_pkg::idx_t      pop_idx_i,
  output axi_bus_pkg::slv_id_t pop_id_o
);
  import axi_bus_pkg::*;
  import remap_pkg::*;

  typedef entry_t [TableSize-1:0] table_t;

  table_t                 tbl_d;
  table_t                 tbl_q;
  logic                   any_free;
  logic [TableSize-1:0]   push_hit;
  logic [TableSize-1:0]   pop_hit;

  // Lowest entry with no bursts in flight
  function automatic logic find_free(input table_t tbl, output idx_t idx);
    logic found;
    found = 1'b0;
    idx   = '0;
    for (int i = int'(TableSize) - 1; i >= 0; i--) begin
      if (tbl[i].cnt == '0) begin
        found = 1'b1;
        idx   = idx_t'(i);
      end
    end
    return found;
  endfunction

  // Lowest live entry that carries the given input ID
  function automatic logic find_match(input table_t tbl, input slv_id_t id, output idx_t idx);
    logic found;
    found = 1'b0;
    idx   = '0;
    for (int i = int'(TableSize) - 1; i >= 0; i--) begin
      if (tbl[i].cnt != '0 && tbl[i].inp_id == id) begin
        found = 1'b1;
        idx   = idx_t'(i);
      end
    end
    return found;
  endfunction

  always_comb begin
    any_free = find_free(tbl_q, free_idx_o);
    exists_o = find_match(tbl_q, lookup_id_i, exists_idx_o);
  end

  assign full_o = !any_free;

  // Read out the count of the matching entry and the input ID of the popped one
  always_comb begin
    exists_full_o = 1'b0;
    pop_id_o      = '0;
    for (int i = 0; i < int'(TableSize); i++) begin
      if (exists_o && exists_idx_o == idx_t'(i)) begin
        exists_full_o = (tbl_q[i].cnt == cnt_t'(TableSize));
      end
      if (pop_idx_i == idx_t'(i)) begin
        pop_id_o = tbl_q[i].inp_id;
      end
    end
  end

  for (genvar g = 0; g < TableSize; g++) begin : gen_hit
    assign push_hit[g] = push_i && (push_idx_i == idx_t'(g));
    assign pop_hit[g]  = pop_i && (pop_idx_i == idx_t'(g));
  end

  always_comb begin
    tbl_d = tbl_q;
    for (int i = 0; i < int'(TableSize); i++) begin
      if (push_hit[i]) begin
        tbl_d[i].inp_id = push_id_i;
      end
      // Push and pop on the same entry cancel out
      if (push_hit[i] && !pop_hit[i]) begin
        tbl_d[i].cnt = tbl_q[i].cnt + 1'b1;
      end else if (pop_hit[i] && !push_hit[i]) begin
        tbl_d[i].cnt = tbl_q[i].cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tbl_q <= '0;
    end else begin
      tbl_q <= tbl_d;
    end
  end

endmodule

//--- remap/remap_issue.sv
// Address channel issue control of one direction; admits requests, remaps IDs and holds stalls
module remap_issue #(
  parameter int unsigned TableSize = remap_pkg::MaxTableSize
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  axi_bus_pkg::slv_ax_t slv_ax_i,
  input  logic                 slv_valid_i,
  output logic                 slv_ready_o,
  output axi_bus_pkg::mst_ax_t mst_ax_o,
  output logic                 mst_valid_o,
  input  logic                 mst_ready_i,
  output axi_bus_pkg::slv_id_t lookup_id_o,
  input  logic                 exists_i,
  input  logic                 exists_full_i,
  input  remap_pkg::idx_t      exists_idx_i,
  input  remap_pkg::idx_t      free_idx_i,
  input  logic                 full_i,
  output logic                 push_o,
  output remap_pkg::idx_t      push_idx_o
);
  import axi_bus_pkg::*;
  import remap_pkg::*;

  issue_state_e state_d;
  issue_state_e state_q;
  idx_t         hold_idx_q;
  idx_t         new_idx;
  idx_t         out_idx;
  logic         admit;
  logic         hold_load;

  assign lookup_id_o = slv_ax_i.id;

  // Same input ID in flight: reuse its entry unless saturated, else need a free one
  assign admit   = exists_i ? !exists_full_i : !full_i;
  assign new_idx = exists_i ? exists_idx_i : free_idx_i;

  always_comb begin
    state_d     = state_q;
    mst_valid_o = 1'b0;
    slv_ready_o = 1'b0;
    push_o      = 1'b0;
    hold_load   = 1'b0;
    out_idx     = new_idx;
    case (state_q)
      Idle: begin
        if (slv_valid_i && admit) begin
          mst_valid_o = 1'b1;
          slv_ready_o = mst_ready_i;
          push_o      = 1'b1;
          if (!mst_ready_i) begin
            hold_load = 1'b1;
            state_d   = Hold;
          end
        end
      end
      Hold: begin
        // Already pushed, keep presenting the frozen ID
        out_idx     = hold_idx_q;
        mst_valid_o = 1'b1;
        slv_ready_o = mst_ready_i;
        if (mst_ready_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  assign push_idx_o = out_idx;

  assign mst_ax_o.id   = mst_id_t'(out_idx);
  assign mst_ax_o.addr = slv_ax_i.addr;
  assign mst_ax_o.len  = slv_ax_i.len;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hold_load) begin
      hold_idx_q <= new_idx;
    end
  end

endmodule

//--- logic/id_remap_top.sv
// Top level of the AXI ID remapper; compacts request IDs and restores them on B and R
module id_remap_top #(
  parameter int unsigned TableSize = remap_pkg::MaxTableSize
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Slave side, facing the upstream manager
  input  axi_bus_pkg::slv_ax_t slv_aw_i,
  input  logic                 slv_aw_valid_i,
  output logic                 slv_aw_ready_o,
  input  axi_bus_pkg::w_chan_t slv_w_i,
  input  logic                 slv_w_valid_i,
  output logic                 slv_w_ready_o,
  output axi_bus_pkg::slv_b_t  slv_b_o,
  output logic                 slv_b_valid_o,
  input  logic                 slv_b_ready_i,
  input  axi_bus_pkg::slv_ax_t slv_ar_i,
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  output axi_bus_pkg::slv_r_t  slv_r_o,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i,
  // Master side, facing the downstream subordinate
  output axi_bus_pkg::mst_ax_t mst_aw_o,
  output logic                 mst_aw_valid_o,
  input  logic                 mst_aw_ready_i,
  output axi_bus_pkg::w_chan_t mst_w_o,
  output logic                 mst_w_valid_o,
  input  logic                 mst_w_ready_i,
  input  axi_bus_pkg::mst_b_t  mst_b_i,
  input  logic                 mst_b_valid_i,
  output logic                 mst_b_ready_o,
  output axi_bus_pkg::mst_ax_t mst_ar_o,
  output logic                 mst_ar_valid_o,
  input  logic                 mst_ar_ready_i,
  input  axi_bus_pkg::mst_r_t  mst_r_i,
  input  logic                 mst_r_valid_i,
  output logic                 mst_r_ready_o
);
  import axi_bus_pkg::*;
  import remap_pkg::*;

  slv_id_t wr_lookup_id;
  slv_id_t rd_lookup_id;
  slv_id_t wr_pop_id;
  slv_id_t rd_pop_id;
  idx_t    wr_exists_idx;
  idx_t    rd_exists_idx;
  idx_t    wr_free_idx;
  idx_t    rd_free_idx;
  idx_t    wr_push_idx;
  idx_t    rd_push_idx;
  logic    wr_exists;
  logic    rd_exists;
  logic    wr_exists_full;
  logic    rd_exists_full;
  logic    wr_full;
  logic    rd_full;
  logic    wr_push;
  logic    rd_push;
  logic    wr_pop;
  logic    rd_pop;

  // W needs no remapping
  assign mst_w_o        = slv_w_i;
  assign mst_w_valid_o  = slv_w_valid_i;
  assign slv_w_ready_o  = mst_w_ready_i;

  // A write burst ends with its B, a read burst with its last R beat
  assign wr_pop = mst_b_valid_i && slv_b_ready_i;
  assign rd_pop = mst_r_valid_i && slv_r_ready_i && mst_r_i.last;

  assign slv_b_o.id     = wr_pop_id;
  assign slv_b_o.resp   = mst_b_i.resp;
  assign slv_b_valid_o  = mst_b_valid_i;
  assign mst_b_ready_o  = slv_b_ready_i;

  assign slv_r_o.id     = rd_pop_id;
  assign slv_r_o.data   = mst_r_i.data;
  assign slv_r_o.resp   = mst_r_i.resp;
  assign slv_r_o.last   = mst_r_i.last;
  assign slv_r_valid_o  = mst_r_valid_i;
  assign mst_r_ready_o  = slv_r_ready_i;

  remap_issue #(
    .TableSize     ( TableSize      )
  ) u_aw_issue (
    .clk_i,
    .rst_ni,
    .slv_ax_i      ( slv_aw_i       ),
    .slv_valid_i   ( slv_aw_valid_i ),
    .slv_ready_o   ( slv_aw_ready_o ),
    .mst_ax_o      ( mst_aw_o       ),
    .mst_valid_o   ( mst_aw_valid_o ),
    .mst_ready_i   ( mst_aw_ready_i ),
    .lookup_id_o   ( wr_lookup_id   ),
    .exists_i      ( wr_exists      ),
    .exists_full_i ( wr_exists_full ),
    .exists_idx_i  ( wr_exists_idx  ),
    .free_idx_i    ( wr_free_idx    ),
    .full_i        ( wr_full        ),
    .push_o        ( wr_push        ),
    .push_idx_o    ( wr_push_idx    )
  );

  remap_table #(
    .TableSize     ( TableSize      )
  ) u_wr_table (
    .clk_i,
    .rst_ni,
    .lookup_id_i   ( wr_lookup_id   ),
    .exists_o      ( wr_exists      ),
    .exists_full_o ( wr_exists_full ),
    .exists_idx_o  ( wr_exists_idx  ),
    .free_idx_o    ( wr_free_idx    ),
    .full_o        ( wr_full        ),
    .push_i        ( wr_push        ),
    .push_idx_i    ( wr_push_idx    ),
    .push_id_i     ( slv_aw_i.id    ),
    .pop_i         ( wr_pop         ),
    .pop_idx_i     ( idx_t'(mst_b_i.id) ),
    .pop_id_o      ( wr_pop_id      )
  );

  remap_issue #(
    .TableSize     ( TableSize      )
  ) u_ar_issue (
    .clk_i,
    .rst_ni,
    .slv_ax_i      ( slv_ar_i       ),
    .slv_valid_i   ( slv_ar_valid_i ),
    .slv_ready_o   ( slv_ar_ready_o ),
    .mst_ax_o      ( mst_ar_o       ),
    .mst_valid_o   ( mst_ar_valid_o ),
    .mst_ready_i   ( mst_ar_ready_i ),
    .lookup_id_o   ( rd_lookup_id   ),
    .exists_i      ( rd_exists      ),
    .exists_full_i ( rd_exists_full ),
    .exists_idx_i  ( rd_exists_idx  ),
    .free_idx_i    ( rd_free_idx    ),
    .full_i        ( rd_full        ),
    .push_o        ( rd_push        ),
    .push_idx_o    ( rd_push_idx    )
  );

  remap_table #(
    .TableSize     ( TableSize      )
  ) u_rd_table (
    .clk_i,
    .rst_ni,
    .lookup_id_i   ( rd_lookup_id   ),
    .exists_o      ( rd_exists      ),
    .exists_full_o ( rd_exists_full ),
    .exists_idx_o  ( rd_exists_idx  ),
    .free_idx_o    ( rd_free_idx    ),
    .full_o        ( rd_full        ),
    .push_i        ( rd_push        ),
    .push_idx_i    ( rd_push_idx    ),
    .push_id_i     ( slv_ar_i.id    ),
    .pop_i         ( rd_pop         ),
    .pop_idx_i     ( idx_t'(mst_r_i.id) ),
    .pop_id_o      ( rd_pop_id      )
  );

endmodule

//--- bench/tb_clock_gen.sv
// Clock and reset source for the testbench; free-running clock, reset held low for a few cycles
module tb_clock_gen #(
  parameter int unsigned HalfPeriod  = 10,
  parameter int unsigned ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HalfPeriod) clk_o = ~clk_o;
    end
  end

  // Release comes on a rising edge, after the flops have sampled it low
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- bench/tb_id_remap.sv
// Testbench for the ID remapper; plays the pattern file as manager and subordinate and checks
module tb_id_remap;
  timeunit 1ns;
  timeprecision 100ps;
  import axi_bus_pkg::*;

  // Small table so that the full case is reached quickly
  localparam int unsigned TableSize     = 4;
  localparam int unsigned MaxSteps      = 64;
  localparam int unsigned Fields        = 6;
  localparam int unsigned CyclesPerStep = 20;
  localparam int unsigned WaitLimit     = 8;
  localparam int unsigned SettleDelay   = 5;
  localparam logic [31:0] LfsrSeed      = 32'h3c110f17;
  localparam logic [31:0] LfsrTaps      = 32'h80200003;

  // Operation codes of the pattern file
  localparam logic [31:0] OpEnd   = 32'd0;
  localparam logic [31:0] OpAr    = 32'd1;
  localparam logic [31:0] OpAw    = 32'd2;
  localparam logic [31:0] OpR     = 32'd3;
  localparam logic [31:0] OpB     = 32'd4;
  localparam logic [31:0] OpW     = 32'd5;
  localparam logic [31:0] OpArOff = 32'd6;
  localparam logic [31:0] OpAwOff = 32'd7;

  // Named after the DUT ports so that the instance connects by name
  logic        clk_i;
  logic        rst_ni;
  slv_ax_t     slv_aw_i;
  logic        slv_aw_valid_i;
  logic        slv_aw_ready_o;
  w_chan_t     slv_w_i;
  logic        slv_w_valid_i;
  logic        slv_w_ready_o;
  slv_b_t      slv_b_o;
  logic        slv_b_valid_o;
  logic        slv_b_ready_i;
  slv_ax_t     slv_ar_i;
  logic        slv_ar_valid_i;
  logic        slv_ar_ready_o;
  slv_r_t      slv_r_o;
  logic        slv_r_valid_o;
  logic        slv_r_ready_i;
  mst_ax_t     mst_aw_o;
  logic        mst_aw_valid_o;
  logic        mst_aw_ready_i;
  w_chan_t     mst_w_o;
  logic        mst_w_valid_o;
  logic        mst_w_ready_i;
  mst_b_t      mst_b_i;
  logic        mst_b_valid_i;
  logic        mst_b_ready_o;
  mst_ax_t     mst_ar_o;
  logic        mst_ar_valid_o;
  logic        mst_ar_ready_i;
  mst_r_t      mst_r_i;
  logic        mst_r_valid_i;
  logic        mst_r_ready_o;

  logic [31:0] pat_mem [MaxSteps * Fields];
  logic [31:0] lfsr_state;
  logic        ar_pending;
  logic        aw_pending;
  int unsigned num_steps;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;
  int unsigned chk_cnt;
  int unsigned err_cnt;

  tb_clock_gen u_clock_gen (
    .clk_o  ( clk_i  ),
    .rst_no ( rst_ni )
  );

  id_remap_top #(
    .TableSize ( TableSize )
  ) DUT (.*);

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (act !== exp) begin
      $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", what, exp, act);
      err_cnt++;
    end
  endtask

  // Galois LFSR, stepped once per bit taken
  function automatic logic take_rand_bit();
    logic b;
    b          = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ LfsrTaps;
    end
    return b;
  endfunction

  // First stall cycle is always low, then random until the window ends
  function automatic logic stall_ready(input int unsigned k, input int unsigned stall);
    if (k >= stall) begin
      return 1'b1;
    end
    if (k == 0) begin
      return 1'b0;
    end
    return take_rand_bit();
  endfunction

  function automatic string step_name(input int unsigned s, input logic [31:0] op);
    string kind;
    case (op)
      OpAr:    kind = "AR";
      OpAw:    kind = "AW";
      OpR:     kind = "R";
      OpB:     kind = "B";
      OpW:     kind = "W";
      OpArOff: kind = "AR held off";
      OpAwOff: kind = "AW held off";
      default: kind = "unknown";
    endcase
    return $sformatf("step %0d %s", s, kind);
  endfunction

  // A held-off request keeps its valid and payload across later steps
  task automatic clear_inputs();
    slv_aw_valid_i = aw_pending;
    slv_ar_valid_i = ar_pending;
    mst_aw_ready_i = 1'b0;
    mst_ar_ready_i = 1'b0;
    slv_w_valid_i  = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    mst_r_valid_i  = 1'b0;
    slv_r_ready_i  = 1'b0;
  endtask

  task automatic drive_request(input logic is_read, input slv_ax_t ax, input logic rdy);
    if (is_read) begin
      slv_ar_i       = ax;
      slv_ar_valid_i = 1'b1;
      mst_ar_ready_i = rdy;
    end else begin
      slv_aw_i       = ax;
      slv_aw_valid_i = 1'b1;
      mst_aw_ready_i = rdy;
    end
  endtask

  task automatic issue_request(input string tag, input logic is_read, input slv_ax_t ax,
                               input int unsigned stall, input mst_id_t exp_id);
    int unsigned k;
    int unsigned waited;
    logic        rdy;
    logic        seen;
    logic        done;
    logic        valid;
    mst_ax_t     fwd;
    k      = 0;
    waited = 0;
    seen   = 1'b0;
    done   = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      clear_inputs();
      rdy = stall_ready(k, stall);
      drive_request(is_read, ax, rdy);
      #(SettleDelay);
      valid = is_read ? mst_ar_valid_o : mst_aw_valid_o;
      fwd   = is_read ? mst_ar_o : mst_aw_o;
      if (valid) begin
        if (!seen) begin
          check_value({tag, " forward latency"}, 32'd0, 32'(waited));
        end
        seen = 1'b1;
        check_value({tag, " id"}, 32'(exp_id), 32'(fwd.id));
        check_value({tag, " addr"}, ax.addr, fwd.addr);
        check_value({tag, " len"}, 32'(ax.len), 32'(fwd.len));
        check_value({tag, " upstream ready"}, 32'(rdy),
                    32'(is_read ? slv_ar_ready_o : slv_aw_ready_o));
        done = rdy;
        k++;
      end else if (seen) begin
        $display("%s: downstream valid dropped before the handshake", tag);
        err_cnt++;
        done = 1'b1;
      end else begin
        waited++;
        if (waited >= WaitLimit) begin
          $display("%s: request with input ID 0x%0h was never forwarded", tag, ax.id);
          err_cnt++;
          done = 1'b1;
        end
      end
      @(posedge clk_i);
    end
    if (is_read) begin
      ar_pending = 1'b0;
    end else begin
      aw_pending = 1'b0;
    end
    // With upstream valid gone no second request may appear
    @(negedge clk_i);
    clear_inputs();
    #(SettleDelay);
    valid = is_read ? mst_ar_valid_o : mst_aw_valid_o;
    check_value({tag, " valid after handshake"}, 32'd0, 32'(valid));
    @(posedge clk_i);
  endtask

  task automatic hold_off_request(input string tag, input logic is_read, input slv_ax_t ax,
                                  input int unsigned stall);
    int unsigned k;
    int unsigned cycles;
    cycles = (stall == 0) ? 1 : stall;
    for (k = 0; k < cycles; k++) begin
      @(negedge clk_i);
      clear_inputs();
      drive_request(is_read, ax, 1'b1);
      #(SettleDelay);
      check_value({tag, " downstream valid"}, 32'd0,
                  32'(is_read ? mst_ar_valid_o : mst_aw_valid_o));
      check_value({tag, " upstream ready"}, 32'd0,
                  32'(is_read ? slv_ar_ready_o : slv_aw_ready_o));
      @(posedge clk_i);
    end
    if (is_read) begin
      ar_pending = 1'b1;
    end else begin
      aw_pending = 1'b1;
    end
  endtask

  task automatic play_response(input string tag, input logic is_read, input mst_id_t idx,
                               input data_t data, input logic last, input int unsigned stall,
                               input slv_id_t exp_id);
    int unsigned k;
    logic        rdy;
    logic        done;
    k    = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      clear_inputs();
      rdy = stall_ready(k, stall);
      if (is_read) begin
        mst_r_i       = '{id: idx, data: data, resp: resp_t'(data[1:0]), last: last};
        mst_r_valid_i = 1'b1;
        slv_r_ready_i = rdy;
      end else begin
        mst_b_i       = '{id: idx, resp: resp_t'(data[1:0])};
        mst_b_valid_i = 1'b1;
        slv_b_ready_i = rdy;
      end
      #(SettleDelay);
      if (is_read) begin
        check_value({tag, " valid"}, 32'd1, 32'(slv_r_valid_o));
        check_value({tag, " id"}, 32'(exp_id), 32'(slv_r_o.id));
        check_value({tag, " data"}, data, slv_r_o.data);
        check_value({tag, " resp"}, 32'(data[1:0]), 32'(slv_r_o.resp));
        check_value({tag, " last"}, 32'(last), 32'(slv_r_o.last));
        check_value({tag, " ready"}, 32'(rdy), 32'(mst_r_ready_o));
      end else begin
        check_value({tag, " valid"}, 32'd1, 32'(slv_b_valid_o));
        check_value({tag, " id"}, 32'(exp_id), 32'(slv_b_o.id));
        check_value({tag, " resp"}, 32'(data[1:0]), 32'(slv_b_o.resp));
        check_value({tag, " ready"}, 32'(rdy), 32'(mst_b_ready_o));
      end
      done = rdy;
      k++;
      @(posedge clk_i);
    end
  endtask

  // Strobe is taken from the low data nibble
  // Downstream ready stays low in the first cycle of each beat
  task automatic send_w_beat(input string tag, input data_t data, input logic last);
    int unsigned k;
    logic        rdy;
    logic        done;
    k    = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      clear_inputs();
      rdy           = stall_ready(k, 1);
      slv_w_i       = '{data: data, strb: strb_t'(data[3:0]), last: last};
      slv_w_valid_i = 1'b1;
      mst_w_ready_i = rdy;
      #(SettleDelay);
      check_value({tag, " valid"}, 32'd1, 32'(mst_w_valid_o));
      check_value({tag, " data"}, data, mst_w_o.data);
      check_value({tag, " strb"}, 32'(data[3:0]), 32'(mst_w_o.strb));
      check_value({tag, " last"}, 32'(last), 32'(mst_w_o.last));
      check_value({tag, " ready"}, 32'(rdy), 32'(slv_w_ready_o));
      done = rdy;
      k++;
      @(posedge clk_i);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin
    int unsigned base;
    int unsigned stall;
    logic [31:0] op;
    logic [31:0] exp_val;
    slv_ax_t     ax;
    string       tag;
    for (int i = 0; i < int'(MaxSteps * Fields); i++) begin
      pat_mem[i] = '0;
    end
    lfsr_state = LfsrSeed;
    chk_cnt    = 0;
    err_cnt    = 0;
    ar_pending = 1'b0;
    aw_pending = 1'b0;
    slv_aw_i   = '0;
    slv_ar_i   = '0;
    slv_w_i    = '0;
    mst_b_i    = '0;
    mst_r_i    = '0;
    clear_inputs();
    $readmemh("bench/remap_patterns.mem", pat_mem);
    num_steps = 0;
    while (num_steps < MaxSteps && pat_mem[num_steps * Fields] != OpEnd) begin
      num_steps++;
    end
    cycle_limit = num_steps * CyclesPerStep;
    if (num_steps == 0) begin
      $display("Pattern file holds no steps");
      err_cnt++;
    end else begin
      wait (rst_ni === 1'b1);
      for (int unsigned s = 0; s < num_steps; s++) begin
        base    = s * Fields;
        op      = pat_mem[base];
        ax.id   = slv_id_t'(pat_mem[base + 1]);
        ax.addr = pat_mem[base + 2];
        ax.len  = len_t'(pat_mem[base + 3]);
        stall   = pat_mem[base + 4];
        exp_val = pat_mem[base + 5];
        tag     = step_name(s, op);
        case (op)
          OpAr:    issue_request(tag, 1'b1, ax, stall, mst_id_t'(exp_val));
          OpAw:    issue_request(tag, 1'b0, ax, stall, mst_id_t'(exp_val));
          OpArOff: hold_off_request(tag, 1'b1, ax, stall);
          OpAwOff: hold_off_request(tag, 1'b0, ax, stall);
          OpR, OpB: begin
            play_response(tag, op == OpR, mst_id_t'(pat_mem[base + 1]), pat_mem[base + 2],
                          pat_mem[base + 3][0], stall, slv_id_t'(exp_val));
          end
          OpW:     send_w_beat(tag, pat_mem[base + 2], pat_mem[base + 3][0]);
          default: begin
            $display("%s: unknown operation code 0x%0h", tag, op);
            err_cnt++;
          end
        endcase
      end
    end
    finish_run();
  end

  // Stops a run that hangs, the limit scales with the number of steps
  initial begin
    cycle_cnt = 0;
    wait (rst_ni === 1'b1);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    err_cnt++;
    finish_run();
  end

endmodule

//--- bench/remap_patterns.mem
// Columns: op id addr_or_data len_or_last stall expected, all hex, one step per line
// op 1 AR, 2 AW, 3 R, 4 B, 5 W, 6 AR held off, 7 AW held off, 0 ends; id is output ID on R and B
// New read IDs take the lowest free output IDs
1 05 00001000 03 00 0
1 2a 00002040 00 00 1
1 11 00003080 07 00 2
1 3f 000040c0 01 00 3
// Reuse of in-flight IDs, the second one stalled downstream
1 2a 00005000 02 00 1
1 05 00006000 0f 03 0
// Read table full, writes still issue
6 20 00007000 01 04 0
2 05 10000000 01 00 0
5 00 a5a5a5a0 00 00 0
5 00 5a5a5a5f 01 00 0
2 07 10000100 00 02 1
5 00 0badf00d 01 00 0
// Burst on output ID 2 completes, the held read takes its slot
3 02 cafe0001 00 00 11
3 02 cafe0002 01 00 11
1 20 00007000 01 00 2
3 01 12345678 01 00 2a
3 01 87654321 01 01 2a
1 33 00008000 00 00 1
3 03 deadbeef 01 00 3f
3 00 00000010 01 00 05
3 00 00000020 01 02 05
1 0c 00009000 04 00 0
// Write side frees and reuses entries
4 01 00000000 00 00 07
2 05 10000200 00 00 0
2 19 10000300 00 01 1
5 00 00000001 01 00 0
4 00 00000001 00 00 05
4 00 00000002 00 00 05
2 3c 10000400 00 00 0
4 01 00000003 00 02 19
// Write table full, reads still issue
2 01 10000500 00 00 1
2 02 10000600 00 00 2
2 03 10000700 00 00 3
7 04 10000800 00 03 0
1 15 0000a000 00 00 3
4 02 00000000 00 00 02
2 04 10000800 00 01 2
// One input ID up to the counter limit
1 15 0000a100 00 00 3
1 15 0000a200 00 00 3
1 15 0000a300 00 00 3
6 15 0000a400 00 03 0
3 03 feedface 01 00 15
1 15 0000a400 00 00 3
0 00 00000000 00 00 0

//--- sim.f
common/axi_bus_pkg.sv
common/remap_pkg.sv
remap/remap_table.sv
remap/remap_issue.sv
logic/id_remap_top.sv
bench/tb_clock_gen.sv
bench/tb_id_remap.sv

//--- Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f sim.f --top-module tb_id_remap
	verilator --lint-only --timescale 1ns/100ps common/axi_bus_pkg.sv common/remap_pkg.sv \
	  remap/remap_table.sv remap/remap_issue.sv logic/id_remap_top.sv --top-module id_remap_top

sim:
	verilator --binary -j 0 -Wno-fatal --timescale 1ns/100ps -f sim.f --top-module tb_id_remap
	./obj_dir/Vtb_id_remap | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
